// File: design/lane_opbus_pkg.sv
////////////////////
// Widths, queue depth, operation codes and bus owners of the lane operand bus
////////////////////

`default_nettype none

package lane_opbus_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One operand-bus word
  localparam int unsigned ELEN_W = 64;
  // One strobe bit per byte of a word
  localparam int unsigned STRB_W = ELEN_W / 8;

  // Matches the number of instructions in flight
  localparam int unsigned ORDER_DEPTH = 8;
  localparam int unsigned ORDER_CNT_W = 4;
  localparam int unsigned ORDER_PTR_W = $clog2(ORDER_DEPTH);

  typedef logic [ELEN_W-1:0] elen_t;
  typedef logic [STRB_W-1:0] strb_t;

  ////////////////////
  // Encodings
  ////////////////////

  // Operation codes seen by the lane
  typedef enum logic [2:0] {
    OP_OTHER     = 3'd0,
    OP_SLIDEUP   = 3'd1,
    OP_SLIDEDOWN = 3'd2,
    OP_IDX_LOAD  = 3'd3,
    OP_IDX_STORE = 3'd4,
    OP_RED_INT   = 3'd5,
    OP_RED_FP    = 3'd6
  } vfu_op_e;

  // Who drives the shared operand bus
  typedef enum logic [1:0] {
    OWN_SLIDE   = 2'd0,
    OWN_ADDRGEN = 2'd1,
    OWN_ALU_RED = 2'd2,
    OWN_FPU_RED = 2'd3
  } bus_owner_e;

endpackage : lane_opbus_pkg

`default_nettype wire

// File: design/lane_opbus_top.sv
////////////////////
// Lane operand-bus arbitration with the mask strobe spill register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module lane_opbus_top
  import lane_opbus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  // Operations from the sequencer
  input  logic    vfu_op_valid_i,
  input  vfu_op_e vfu_op_i,
  // Completion pulses
  input  logic    opq_cmd_pop_i,
  input  logic    alu_red_complete_i,
  input  logic    fpu_red_complete_i,
  // Operand queue stream
  input  elen_t   opq_operand_i,
  input  logic    opq_valid_i,
  output logic    opq_ready_o,
  // Reduction streams from the ALU and FPU
  input  elen_t   alu_red_data_i,
  input  logic    alu_red_valid_i,
  output logic    alu_red_gnt_o,
  input  elen_t   fpu_red_data_i,
  input  logic    fpu_red_valid_i,
  output logic    fpu_red_gnt_o,
  // Shared bus toward slide unit and address generator
  output elen_t   sldu_operand_o,
  output logic    sldu_operand_valid_o,
  input  logic    sldu_operand_ready_i,
  output logic    addrgen_operand_valid_o,
  input  logic    addrgen_operand_ready_i,
  // Slide unit back to the functional units
  input  logic    sldu_red_valid_i,
  output logic    alu_red_valid_o,
  output logic    fpu_red_valid_o,
  input  logic    sldu_result_gnt_opq_i,
  input  logic    alu_red_ready_i,
  input  logic    fpu_red_ready_i,
  output logic    sldu_result_gnt_o,
  // Mask strobes
  input  strb_t   mask_i,
  input  logic    mask_valid_i,
  output logic    mask_ready_o,
  output strb_t   mask_o,
  output logic    mask_valid_o,
  input  logic    mask_ready_i
);

  bus_owner_e head_owner;
  logic       head_valid;

  opbus_order_queue u_order_queue (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .flush_i            (flush_i),
    .vfu_op_valid_i     (vfu_op_valid_i),
    .vfu_op_i           (vfu_op_i),
    .opq_cmd_pop_i      (opq_cmd_pop_i),
    .alu_red_complete_i (alu_red_complete_i),
    .fpu_red_complete_i (fpu_red_complete_i),
    .head_owner_o       (head_owner),
    .head_valid_o       (head_valid)
  );

  opbus_steer u_steer (
    .head_owner_i            (head_owner),
    .head_valid_i            (head_valid),
    .opq_operand_i           (opq_operand_i),
    .opq_valid_i             (opq_valid_i),
    .alu_red_data_i          (alu_red_data_i),
    .fpu_red_data_i          (fpu_red_data_i),
    .alu_red_valid_i         (alu_red_valid_i),
    .fpu_red_valid_i         (fpu_red_valid_i),
    .sldu_operand_ready_i    (sldu_operand_ready_i),
    .addrgen_operand_ready_i (addrgen_operand_ready_i),
    .sldu_red_valid_i        (sldu_red_valid_i),
    .sldu_result_gnt_opq_i   (sldu_result_gnt_opq_i),
    .alu_red_ready_i         (alu_red_ready_i),
    .fpu_red_ready_i         (fpu_red_ready_i),
    .opq_ready_o             (opq_ready_o),
    .alu_red_gnt_o           (alu_red_gnt_o),
    .fpu_red_gnt_o           (fpu_red_gnt_o),
    .sldu_operand_o          (sldu_operand_o),
    .sldu_operand_valid_o    (sldu_operand_valid_o),
    .addrgen_operand_valid_o (addrgen_operand_valid_o),
    .alu_red_valid_o         (alu_red_valid_o),
    .fpu_red_valid_o         (fpu_red_valid_o),
    .sldu_result_gnt_o       (sldu_result_gnt_o)
  );

  // Cuts the timing path on the mask ready
  mask_spill_reg u_mask_spill (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mask_i       (mask_i),
    .mask_valid_i (mask_valid_i),
    .mask_ready_i (mask_ready_i),
    .mask_ready_o (mask_ready_o),
    .mask_o       (mask_o),
    .mask_valid_o (mask_valid_o)
  );

endmodule : lane_opbus_top

`default_nettype wire

// File: design/mask_spill_reg.sv
////////////////////
// Two-entry spill register on the mask strobe stream
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mask_spill_reg
  import lane_opbus_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  strb_t mask_i,
  input  logic  mask_valid_i,
  input  logic  mask_ready_i,
  output logic  mask_ready_o,
  output strb_t mask_o,
  output logic  mask_valid_o
);

  // Main slot takes new strobes, spill slot keeps the older one on a stall
  logic  main_full_q;
  strb_t main_data_q;
  logic  spill_full_q;
  strb_t spill_data_q;

  logic  main_fill;
  logic  main_drain;
  logic  spill_fill;
  logic  spill_drain;

  assign main_fill   = mask_valid_i & mask_ready_o;
  assign main_drain  = main_full_q & ~spill_full_q;
  assign spill_fill  = main_drain & ~mask_ready_i;
  assign spill_drain = spill_full_q & mask_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (main_fill || main_drain) begin
        main_full_q <= main_fill;
      end
      if (spill_fill || spill_drain) begin
        spill_full_q <= spill_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_fill) begin
      main_data_q <= mask_i;
    end
    if (spill_fill) begin
      spill_data_q <= main_data_q;
    end
  end

  // Upstream ready depends on local state only
  assign mask_ready_o = ~main_full_q | ~spill_full_q;
  assign mask_valid_o = main_full_q | spill_full_q;
  // Spill slot holds the older strobe
  assign mask_o       = spill_full_q ? spill_data_q : main_data_q;

  // A stalled strobe stays offered and unchanged
  a_mask_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mask_valid_o && !mask_ready_i) |=> (mask_valid_o && $stable(mask_o)))
    else $error("mask spill: strobe changed while stalled");

endmodule : mask_spill_reg

`default_nettype wire

// File: design/opbus_order_queue.sv
////////////////////
// Order queue that keeps the operand-bus owners in instruction order
////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_order_queue
  import lane_opbus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       vfu_op_valid_i,
  input  vfu_op_e    vfu_op_i,
  input  logic       opq_cmd_pop_i,
  input  logic       alu_red_complete_i,
  input  logic       fpu_red_complete_i,
  output bus_owner_e head_owner_o,
  output logic       head_valid_o
);

  typedef logic [ORDER_PTR_W-1:0] ptr_t;

  logic       op_valid_q;
  vfu_op_e    op_q;

  bus_owner_e push_owner;
  logic       push_req;
  logic       push;
  logic       pop;

  bus_owner_e             owner_mem [ORDER_DEPTH];
  ptr_t                   wr_ptr_q;
  ptr_t                   rd_ptr_q;
  logic [ORDER_CNT_W-1:0] count_q;
  logic                   empty;
  logic                   full;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    if (ptr == ptr_t'(ORDER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Operation register
  ////////////////////

  // Cuts the path from the sequencer to the queue write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= vfu_op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q <= vfu_op_i;
  end

  // Map the operation to its bus owner, OP_OTHER takes no entry
  always_comb begin
    push_owner = OWN_SLIDE;
    push_req   = 1'b1;
    case (op_q)
      OP_SLIDEUP, OP_SLIDEDOWN:   push_owner = OWN_SLIDE;
      OP_IDX_LOAD, OP_IDX_STORE:  push_owner = OWN_ADDRGEN;
      OP_RED_INT:                 push_owner = OWN_ALU_RED;
      OP_RED_FP:                  push_owner = OWN_FPU_RED;
      default:                    push_req   = 1'b0;
    endcase
  end

  // A push that meets a flush is dropped
  assign push = op_valid_q & push_req & ~flush_i;

  ////////////////////
  // Owner buffer
  ////////////////////

  assign empty        = (count_q == '0);
  assign full         = (count_q == ORDER_CNT_W'(ORDER_DEPTH));
  assign head_owner_o = owner_mem[rd_ptr_q];
  assign head_valid_o = ~empty;

  // Only the completion of the head's own unit retires it
  always_comb begin
    pop = 1'b0;
    if (!empty) begin
      case (head_owner_o)
        OWN_SLIDE, OWN_ADDRGEN: pop = opq_cmd_pop_i;
        OWN_ALU_RED:            pop = alu_red_complete_i;
        OWN_FPU_RED:            pop = fpu_red_complete_i;
        default:                pop = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      owner_mem[wr_ptr_q] <= push_owner;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // More than ORDER_DEPTH instructions in flight would overwrite the oldest owner
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> (!full || pop))
    else $error("order queue: push while full");

  // A retired owner must lie between the read and write pointers
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop |-> ((wr_ptr_q != rd_ptr_q) || full))
    else $error("order queue: pop while empty");

endmodule : opbus_order_queue

`default_nettype wire

// File: design/opbus_steer.sv
////////////////////
// Steering of the shared operand bus by the head of the order queue
////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_steer
  import lane_opbus_pkg::*;
(
  input  bus_owner_e head_owner_i,
  input  logic       head_valid_i,
  input  elen_t      opq_operand_i,
  input  logic       opq_valid_i,
  input  elen_t      alu_red_data_i,
  input  elen_t      fpu_red_data_i,
  input  logic       alu_red_valid_i,
  input  logic       fpu_red_valid_i,
  input  logic       sldu_operand_ready_i,
  input  logic       addrgen_operand_ready_i,
  input  logic       sldu_red_valid_i,
  input  logic       sldu_result_gnt_opq_i,
  input  logic       alu_red_ready_i,
  input  logic       fpu_red_ready_i,
  output logic       opq_ready_o,
  output logic       alu_red_gnt_o,
  output logic       fpu_red_gnt_o,
  output elen_t      sldu_operand_o,
  output logic       sldu_operand_valid_o,
  output logic       addrgen_operand_valid_o,
  output logic       alu_red_valid_o,
  output logic       fpu_red_valid_o,
  output logic       sldu_result_gnt_o
);

  // Owner decode, all low while the queue is empty
  logic sel_slide;
  logic sel_addrgen;
  logic sel_alu;
  logic sel_fpu;

  assign sel_slide   = head_valid_i & (head_owner_i == OWN_SLIDE);
  assign sel_addrgen = head_valid_i & (head_owner_i == OWN_ADDRGEN);
  assign sel_alu     = head_valid_i & (head_owner_i == OWN_ALU_RED);
  assign sel_fpu     = head_valid_i & (head_owner_i == OWN_FPU_RED);

  ////////////////////
  // Bus source mux
  ////////////////////

  // Slides and indexed accesses share the operand-queue word
  always_comb begin
    sldu_operand_o = '0;
    if (sel_slide || sel_addrgen) begin
      sldu_operand_o = opq_operand_i;
    end else if (sel_alu) begin
      sldu_operand_o = alu_red_data_i;
    end else if (sel_fpu) begin
      sldu_operand_o = fpu_red_data_i;
    end
  end

  // Slide unit sees the operand queue or a reduction source
  assign sldu_operand_valid_o = (sel_slide & opq_valid_i)
                              | (sel_alu & alu_red_valid_i)
                              | (sel_fpu & fpu_red_valid_i);

  // Ready goes back only to the selected source
  assign alu_red_gnt_o = sel_alu & sldu_operand_ready_i;
  assign fpu_red_gnt_o = sel_fpu & sldu_operand_ready_i;

  ////////////////////
  // Operand queue split
  ////////////////////

  assign addrgen_operand_valid_o = sel_addrgen & opq_valid_i;

  always_comb begin
    opq_ready_o = 1'b0;
    if (sel_slide) begin
      opq_ready_o = sldu_operand_ready_i;
    end else if (sel_addrgen) begin
      opq_ready_o = addrgen_operand_ready_i;
    end
  end

  ////////////////////
  // Reduction return
  ////////////////////

  // Slide unit talks straight to the reducing unit
  assign alu_red_valid_o = sel_alu & sldu_red_valid_i;
  assign fpu_red_valid_o = sel_fpu & sldu_red_valid_i;

  always_comb begin
    sldu_result_gnt_o = 1'b0;
    if (sel_slide) begin
      sldu_result_gnt_o = sldu_result_gnt_opq_i;
    end else if (sel_alu) begin
      sldu_result_gnt_o = alu_red_ready_i;
    end else if (sel_fpu) begin
      sldu_result_gnt_o = fpu_red_ready_i;
    end
  end

endmodule : opbus_steer

`default_nettype wire

// File: lane_opbus.f
+incdir+test
design/lane_opbus_pkg.sv
design/opbus_order_queue.sv
design/opbus_steer.sv
design/mask_spill_reg.sv
design/lane_opbus_top.sv
test/tb_lane_opbus.sv

// File: run_sim.sh
#!/bin/sh
# Builds the lane operand-bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --assert -j 0 \
    --top-module tb_lane_opbus \
    -Mdir obj_dir \
    -f lane_opbus.f; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_lane_opbus)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: test/tb_lane_opbus_checks.svh
////////////////////
// Concurrent checks on the routed bus and the mask stream
// Error counters and the mismatch report
////////////////////

`ifndef TB_LANE_OPBUS_CHECKS_SVH
`define TB_LANE_OPBUS_CHECKS_SVH

int unsigned bus_errors = 0;
int unsigned mask_errors = 0;

function automatic void report_mismatch(input string name, input logic [63:0] exp_val,
                                        input logic [63:0] act_val, input logic mask_side);
  if (mask_side) begin
    mask_errors++;
  end else begin
    bus_errors++;
  end
  $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp_val, act_val);
endfunction

////////////////////
// Operand bus
////////////////////

a_operand: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  sldu_operand_o == exp_operand)
  else report_mismatch("sldu_operand_o", $sampled(exp_operand), $sampled(sldu_operand_o), 1'b0);
a_sldu_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  sldu_operand_valid_o == exp_sldu_valid)
  else report_mismatch("sldu_operand_valid_o", 64'($sampled(exp_sldu_valid)),
                       64'($sampled(sldu_operand_valid_o)), 1'b0);
a_addr_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  addrgen_operand_valid_o == exp_addr_valid)
  else report_mismatch("addrgen_operand_valid_o", 64'($sampled(exp_addr_valid)),
                       64'($sampled(addrgen_operand_valid_o)), 1'b0);
a_opq_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  opq_ready_o == exp_opq_ready)
  else report_mismatch("opq_ready_o", 64'($sampled(exp_opq_ready)),
                       64'($sampled(opq_ready_o)), 1'b0);
a_alu_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  alu_red_gnt_o == exp_alu_gnt)
  else report_mismatch("alu_red_gnt_o", 64'($sampled(exp_alu_gnt)),
                       64'($sampled(alu_red_gnt_o)), 1'b0);
a_fpu_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  fpu_red_gnt_o == exp_fpu_gnt)
  else report_mismatch("fpu_red_gnt_o", 64'($sampled(exp_fpu_gnt)),
                       64'($sampled(fpu_red_gnt_o)), 1'b0);

// Reduction return path
a_alu_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  alu_red_valid_o == exp_alu_valid)
  else report_mismatch("alu_red_valid_o", 64'($sampled(exp_alu_valid)),
                       64'($sampled(alu_red_valid_o)), 1'b0);
a_fpu_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  fpu_red_valid_o == exp_fpu_valid)
  else report_mismatch("fpu_red_valid_o", 64'($sampled(exp_fpu_valid)),
                       64'($sampled(fpu_red_valid_o)), 1'b0);
a_result_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  sldu_result_gnt_o == exp_result_gnt)
  else report_mismatch("sldu_result_gnt_o", 64'($sampled(exp_result_gnt)),
                       64'($sampled(sldu_result_gnt_o)), 1'b0);

////////////////////
// Mask stream
////////////////////

a_mask_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  mask_valid_o == exp_mask_valid)
  else report_mismatch("mask_valid_o", 64'($sampled(exp_mask_valid)),
                       64'($sampled(mask_valid_o)), 1'b1);
a_mask_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  mask_ready_o == exp_mask_ready)
  else report_mismatch("mask_ready_o", 64'($sampled(exp_mask_ready)),
                       64'($sampled(mask_ready_o)), 1'b1);
// Oldest accepted strobe is the one on offer
a_mask_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  exp_mask_valid |-> (mask_o == exp_mask_front))
  else report_mismatch("mask_o", 64'($sampled(exp_mask_front)),
                       64'($sampled(mask_o)), 1'b1);

`endif

// File: test/tb_lane_opbus.sv
////////////////////
// Testbench for the lane operand bus
// Random stimulus, reference owner and mask queues, watchdog, final report
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lane_opbus
  import lane_opbus_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 3;
  localparam int N_CYCLES    = 4000;
  localparam int WATCHDOG_NS = (RST_CYCLES + N_CYCLES + 200) * CLK_PERIOD;

  logic    clk_i;
  logic    rst_n_i;
  logic    flush_i;
  logic    vfu_op_valid_i;
  vfu_op_e vfu_op_i;
  logic    opq_cmd_pop_i, alu_red_complete_i, fpu_red_complete_i;
  elen_t   opq_operand_i, alu_red_data_i, fpu_red_data_i;
  logic    opq_valid_i, alu_red_valid_i, fpu_red_valid_i;
  logic    sldu_operand_ready_i, addrgen_operand_ready_i;
  logic    sldu_red_valid_i, sldu_result_gnt_opq_i, alu_red_ready_i, fpu_red_ready_i;
  strb_t   mask_i;
  logic    mask_valid_i, mask_ready_i;
  // DUT outputs
  logic    opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o;
  elen_t   sldu_operand_o;
  logic    sldu_operand_valid_o, addrgen_operand_valid_o;
  logic    alu_red_valid_o, fpu_red_valid_o, sldu_result_gnt_o;
  logic    mask_ready_o, mask_valid_o;
  strb_t   mask_o;

  // Reference state
  bus_owner_e owners[$];
  strb_t      masks[$];
  int         mask_held;
  logic       pend_valid;
  vfu_op_e    pend_op;
  logic [31:0] lfsr_state = 32'h87f2d3e9;

  // Expected values seen by the checks
  logic       exp_head_valid;
  bus_owner_e exp_head_owner;
  int         exp_mask_cnt;
  strb_t      exp_mask_front;
  elen_t      exp_operand;
  logic       exp_sldu_valid, exp_addr_valid, exp_opq_ready, exp_alu_gnt, exp_fpu_gnt;
  logic       exp_alu_valid, exp_fpu_valid, exp_result_gnt;
  logic       exp_mask_valid, exp_mask_ready;

  lane_opbus_top u_lane_opbus_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] val;
    logic        fb;
    int unsigned i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[0];
      val = {val[62:0], fb};
      lfsr_state = {1'b0, lfsr_state[31:1]};
      if (fb) begin
        lfsr_state = lfsr_state ^ 32'h80200003;
      end
    end
    return val;
  endfunction

  function automatic bus_owner_e owner_of(input vfu_op_e op);
    case (op)
      OP_SLIDEUP, OP_SLIDEDOWN:  return OWN_SLIDE;
      OP_IDX_LOAD, OP_IDX_STORE: return OWN_ADDRGEN;
      OP_RED_INT:                return OWN_ALU_RED;
      default:                   return OWN_FPU_RED;
    endcase
  endfunction

  // Completion pulse that belongs to an owner
  function automatic logic completes(input bus_owner_e own);
    case (own)
      OWN_SLIDE, OWN_ADDRGEN: return opq_cmd_pop_i;
      OWN_ALU_RED:            return alu_red_complete_i;
      default:                return fpu_red_complete_i;
    endcase
  endfunction

  // Owners queued plus the one still in the operation register
  function automatic int in_flight();
    int n;
    n = owners.size();
    if (pend_valid && pend_op != OP_OTHER) begin
      n++;
    end
    return n;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      owners.delete();
      masks.delete();
      pend_valid = 1'b0;
      pend_op = OP_OTHER;
    end else begin
      // Two-entry buffer, transfers decided on the occupancy before the edge
      mask_held = masks.size();
      if (mask_held != 0 && mask_ready_i) begin
        void'(masks.pop_front());
      end
      if (mask_valid_i && mask_held < 2) begin
        masks.push_back(mask_i);
      end
      // Flush drops the queue and a push in the same cycle
      if (flush_i) begin
        owners.delete();
      end else begin
        if (owners.size() != 0 && completes(owners[0])) begin
          void'(owners.pop_front());
        end
        if (pend_valid && pend_op != OP_OTHER) begin
          owners.push_back(owner_of(pend_op));
        end
      end
      pend_valid = vfu_op_valid_i;
      pend_op = vfu_op_i;
    end
    exp_head_valid <= (owners.size() != 0);
    exp_head_owner <= (owners.size() != 0) ? owners[0] : OWN_SLIDE;
    exp_mask_cnt <= masks.size();
    exp_mask_front <= (masks.size() != 0) ? masks[0] : '0;
  end

  // Routing expected for the current head owner
  always_comb begin
    exp_operand = '0;
    exp_sldu_valid = 1'b0;
    exp_addr_valid = 1'b0;
    exp_opq_ready = 1'b0;
    exp_alu_gnt = 1'b0;
    exp_fpu_gnt = 1'b0;
    exp_alu_valid = 1'b0;
    exp_fpu_valid = 1'b0;
    exp_result_gnt = 1'b0;
    if (exp_head_valid) begin
      case (exp_head_owner)
        OWN_SLIDE: begin
          exp_operand = opq_operand_i;
          exp_sldu_valid = opq_valid_i;
          exp_opq_ready = sldu_operand_ready_i;
          exp_result_gnt = sldu_result_gnt_opq_i;
        end
        OWN_ADDRGEN: begin
          exp_operand = opq_operand_i;
          exp_addr_valid = opq_valid_i;
          exp_opq_ready = addrgen_operand_ready_i;
        end
        OWN_ALU_RED: begin
          exp_operand = alu_red_data_i;
          exp_sldu_valid = alu_red_valid_i;
          exp_alu_gnt = sldu_operand_ready_i;
          exp_alu_valid = sldu_red_valid_i;
          exp_result_gnt = alu_red_ready_i;
        end
        default: begin
          exp_operand = fpu_red_data_i;
          exp_sldu_valid = fpu_red_valid_i;
          exp_fpu_gnt = sldu_operand_ready_i;
          exp_fpu_valid = sldu_red_valid_i;
          exp_result_gnt = fpu_red_ready_i;
        end
      endcase
    end
    exp_mask_valid = (exp_mask_cnt != 0);
    exp_mask_ready = (exp_mask_cnt < 2);
  end

  `include "tb_lane_opbus_checks.svh"

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic quiet_inputs();
    flush_i = 1'b0;
    vfu_op_valid_i = 1'b0;
    vfu_op_i = OP_OTHER;
    opq_cmd_pop_i = 1'b0;
    alu_red_complete_i = 1'b0;
    fpu_red_complete_i = 1'b0;
    opq_operand_i = '0;
    alu_red_data_i = '0;
    fpu_red_data_i = '0;
    opq_valid_i = 1'b0;
    alu_red_valid_i = 1'b0;
    fpu_red_valid_i = 1'b0;
    sldu_operand_ready_i = 1'b0;
    addrgen_operand_ready_i = 1'b0;
    sldu_red_valid_i = 1'b0;
    sldu_result_gnt_opq_i = 1'b0;
    alu_red_ready_i = 1'b0;
    fpu_red_ready_i = 1'b0;
    mask_i = '0;
    mask_valid_i = 1'b0;
    mask_ready_i = 1'b1;
  endtask

  // Heavy phases fill the queue, light phases let it run empty
  task automatic drive_random(input logic heavy);
    logic want_op;
    want_op = heavy ? 1'(rand_bits(1)) : (rand_bits(3) == '0);
    vfu_op_i = vfu_op_e'(3'(rand_bits(3) % 64'd7));
    vfu_op_valid_i = want_op && (in_flight() < ORDER_DEPTH);
    flush_i = (rand_bits(6) == '0);
    opq_cmd_pop_i = (rand_bits(2) == '0);
    alu_red_complete_i = (rand_bits(2) == '0);
    fpu_red_complete_i = (rand_bits(2) == '0);
    opq_operand_i = rand_bits(64);
    alu_red_data_i = rand_bits(64);
    fpu_red_data_i = rand_bits(64);
    opq_valid_i = 1'(rand_bits(1));
    alu_red_valid_i = 1'(rand_bits(1));
    fpu_red_valid_i = 1'(rand_bits(1));
    sldu_operand_ready_i = 1'(rand_bits(1));
    addrgen_operand_ready_i = 1'(rand_bits(1));
    sldu_red_valid_i = 1'(rand_bits(1));
    sldu_result_gnt_opq_i = 1'(rand_bits(1));
    alu_red_ready_i = 1'(rand_bits(1));
    fpu_red_ready_i = 1'(rand_bits(1));
    mask_i = strb_t'(rand_bits(STRB_W));
    mask_valid_i = 1'(rand_bits(1));
    mask_ready_i = 1'(rand_bits(1));
  endtask

  initial begin
    int cyc;
    quiet_inputs();
    rst_n_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (cyc = 0; cyc < N_CYCLES; cyc++) begin
      drive_random(~cyc[8]);
      @(negedge clk_i);
    end
    // Let the mask stream drain
    quiet_inputs();
    while (mask_valid_o) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    $display("Errors: bus %0d, mask %0d", bus_errors, mask_errors);
    if (bus_errors == 0 && mask_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the stimulus and the mask drain finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_lane_opbus

`default_nettype wire
